// File: logic/cpu_pkg.sv
package cpu_pkg;

localparam int REG_NUM    = 32;
localparam int REG_ADDR_W = 5;
localparam int ROB_DEPTH  = 8;
localparam int ROB_IDX_W  = 3;
localparam int RS_DEPTH   = 4;
localparam int RS_IDX_W   = 2;

// major opcodes
localparam logic [5:0] OP_RTYPE = 6'h00;
localparam logic [5:0] OP_ADDI  = 6'h08;
localparam logic [5:0] OP_SLTI  = 6'h0a;
localparam logic [5:0] OP_ANDI  = 6'h0c;
localparam logic [5:0] OP_ORI   = 6'h0d;
localparam logic [5:0] OP_XORI  = 6'h0e;
localparam logic [5:0] OP_LUI   = 6'h0f;

// funct field of r-format
localparam logic [5:0] FN_SLL = 6'h00;
localparam logic [5:0] FN_ADD = 6'h20;
localparam logic [5:0] FN_SUB = 6'h22;
localparam logic [5:0] FN_AND = 6'h24;
localparam logic [5:0] FN_OR  = 6'h25;
localparam logic [5:0] FN_XOR = 6'h26;
localparam logic [5:0] FN_SLT = 6'h2a;

localparam logic [3:0] ALU_ADD = 4'd0;
localparam logic [3:0] ALU_SUB = 4'd1;
localparam logic [3:0] ALU_AND = 4'd2;
localparam logic [3:0] ALU_OR  = 4'd3;
localparam logic [3:0] ALU_XOR = 4'd4;
localparam logic [3:0] ALU_SLT = 4'd5;
localparam logic [3:0] ALU_SLL = 4'd6;
localparam logic [3:0] ALU_LUI = 4'd7;

typedef union packed {
	struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r;
	struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i;
} instr_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] raddr_a,
	input  logic [REG_ADDR_W-1:0] raddr_b,
	output logic [31:0]           rdata_a,
	output logic [31:0]           rdata_b,
	input  logic                  we,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [31:0]           wdata
);

logic [31:0] regs [REG_NUM];
logic        wr_en;

// r0 is never written, so it keeps its reset value
assign wr_en = we && (waddr != '0);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < REG_NUM; i++)
			regs[i] <= '0;
	end else if (wr_en) begin
		regs[waddr] <= wdata;
	end
end

// write-through on same address
assign rdata_a = (wr_en && waddr == raddr_a) ? wdata : regs[raddr_a];
assign rdata_b = (wr_en && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// File: logic/reg_status.sv
`timescale 1ns/100ps

module reg_status import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] raddr_a,
	input  logic [REG_ADDR_W-1:0] raddr_b,
	output logic                  busy_a,
	output logic                  busy_b,
	output logic [ROB_IDX_W-1:0]  tag_a,
	output logic [ROB_IDX_W-1:0]  tag_b,
	input  logic                  status_set,
	input  logic [REG_ADDR_W-1:0] status_set_addr,
	input  logic [ROB_IDX_W-1:0]  status_set_tag,
	input  logic                  status_clr,
	input  logic [REG_ADDR_W-1:0] status_clr_addr,
	input  logic [ROB_IDX_W-1:0]  status_clr_tag
);

logic [REG_NUM-1:0]   busy;
logic [ROB_IDX_W-1:0] prod_tag [REG_NUM];

assign busy_a = busy[raddr_a];
assign busy_b = busy[raddr_b];
assign tag_a  = prod_tag[raddr_a];
assign tag_b  = prod_tag[raddr_b];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		busy <= '0;
	end else begin
		// only the youngest producer may release the register
		if (status_clr && prod_tag[status_clr_addr] == status_clr_tag)
			busy[status_clr_addr] <= 1'b0;
		// later assignment, so a set wins over a clear
		if (status_set && status_set_addr != '0)
			busy[status_set_addr] <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (status_set)
		prod_tag[status_set_addr] <= status_set_tag;
end

endmodule

// File: logic/rob.sv
`timescale 1ns/100ps

module rob import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rob_push,
	input  logic [REG_ADDR_W-1:0] rob_push_waddr,
	output logic [ROB_IDX_W-1:0]  rob_tail,
	output logic                  rob_full,
	input  logic                  cdb_valid,
	input  logic [ROB_IDX_W-1:0]  cdb_tag,
	input  logic [31:0]           cdb_value,
	input  logic [ROB_IDX_W-1:0]  rob_raddr_a,
	input  logic [ROB_IDX_W-1:0]  rob_raddr_b,
	output logic                  rob_done_a,
	output logic [31:0]           rob_value_a,
	output logic                  rob_done_b,
	output logic [31:0]           rob_value_b,
	output logic                  rob_head_valid,
	output logic                  rob_head_done,
	output logic [REG_ADDR_W-1:0] rob_head_waddr,
	output logic [31:0]           rob_head_value,
	output logic [ROB_IDX_W-1:0]  rob_head_tag,
	input  logic                  rob_pop
);

logic [REG_ADDR_W-1:0] ent_waddr [ROB_DEPTH];
logic [31:0]           ent_value [ROB_DEPTH];
logic [ROB_DEPTH-1:0]  ent_done;
logic [ROB_IDX_W-1:0]  head;
logic [ROB_IDX_W-1:0]  tail;
logic [ROB_IDX_W:0]    count;

assign rob_tail = tail;
assign rob_full = (count == ROB_DEPTH);

assign rob_done_a  = ent_done[rob_raddr_a];
assign rob_value_a = ent_value[rob_raddr_a];
assign rob_done_b  = ent_done[rob_raddr_b];
assign rob_value_b = ent_value[rob_raddr_b];

assign rob_head_valid = (count != '0);
assign rob_head_done  = ent_done[head];
assign rob_head_waddr = ent_waddr[head];
assign rob_head_value = ent_value[head];
assign rob_head_tag   = head;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		head     <= '0;
		tail     <= '0;
		count    <= '0;
		ent_done <= '0;
	end else begin
		// pointers wrap naturally, depth is a power of two
		if (rob_push) begin
			tail           <= tail + 1'b1;
			ent_done[tail] <= 1'b0;
		end
		if (cdb_valid)
			ent_done[cdb_tag] <= 1'b1;
		if (rob_pop)
			head <= head + 1'b1;
		case ({rob_push, rob_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (rob_push)
		ent_waddr[tail] <= rob_push_waddr;
	if (cdb_valid)
		ent_value[cdb_tag] <= cdb_value;
end

endmodule

// File: logic/instr_fetch.sv
`timescale 1ns/100ps

module instr_fetch (
	input  logic        clk,
	input  logic        rst_n,
	output logic        imem_read,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic        fetch_valid,
	output logic [31:0] fetch_instr,
	input  logic        fetch_ack
);

logic [31:0] pc;
logic        pending;
logic [31:0] ibuf [2];
logic        rd_ptr;
logic        wr_ptr;
logic [1:0]  count;
logic [1:0]  count_next;

assign imem_addr   = pc;
assign fetch_valid = (count != 2'd0);
assign fetch_instr = ibuf[rd_ptr];

// occupancy after this cycle, returning word included
assign count_next = count + {1'b0, pending} - {1'b0, fetch_ack};

always_ff @(posedge clk) begin
	if (!rst_n) begin
		pc        <= '0;
		imem_read <= 1'b0;
		pending   <= 1'b0;
		rd_ptr    <= 1'b0;
		wr_ptr    <= 1'b0;
		count     <= '0;
	end else begin
		// request only if the word can land in the buffer
		imem_read <= (count_next + {1'b0, imem_read}) < 2'd2;
		pending   <= imem_read;
		if (imem_read)
			pc <= pc + 32'd4;
		if (pending)
			wr_ptr <= ~wr_ptr;
		if (fetch_ack)
			rd_ptr <= ~rd_ptr;
		count <= count_next;
	end
end

always_ff @(posedge clk) begin
	if (pending)
		ibuf[wr_ptr] <= imem_rdata;
end

endmodule

// File: logic/instr_issue.sv
`timescale 1ns/100ps

module instr_issue import cpu_pkg::*; (
	input  logic                  fetch_valid,
	input  logic [31:0]           fetch_instr,
	output logic                  fetch_ack,
	output logic [REG_ADDR_W-1:0] raddr_a,
	output logic [REG_ADDR_W-1:0] raddr_b,
	input  logic [31:0]           rdata_a,
	input  logic [31:0]           rdata_b,
	input  logic                  busy_a,
	input  logic [ROB_IDX_W-1:0]  tag_a,
	input  logic                  busy_b,
	input  logic [ROB_IDX_W-1:0]  tag_b,
	output logic [ROB_IDX_W-1:0]  rob_raddr_a,
	output logic [ROB_IDX_W-1:0]  rob_raddr_b,
	input  logic                  rob_done_a,
	input  logic [31:0]           rob_value_a,
	input  logic                  rob_done_b,
	input  logic [31:0]           rob_value_b,
	input  logic                  cdb_valid,
	input  logic [ROB_IDX_W-1:0]  cdb_tag,
	input  logic [31:0]           cdb_value,
	input  logic                  rob_full,
	input  logic [ROB_IDX_W-1:0]  rob_tail,
	output logic                  rob_push,
	output logic [REG_ADDR_W-1:0] rob_push_waddr,
	output logic                  status_set,
	output logic [REG_ADDR_W-1:0] status_set_addr,
	output logic [ROB_IDX_W-1:0]  status_set_tag,
	input  logic                  rs_full,
	output logic                  rs_push,
	output logic [3:0]            rs_alu_op,
	output logic [31:0]           rs_val_a,
	output logic                  rs_rdy_a,
	output logic [ROB_IDX_W-1:0]  rs_tag_a,
	output logic [31:0]           rs_val_b,
	output logic                  rs_rdy_b,
	output logic [ROB_IDX_W-1:0]  rs_tag_b,
	output logic [ROB_IDX_W-1:0]  rs_tag
);

instr_t                ins;
logic [3:0]            alu_op;
logic [REG_ADDR_W-1:0] dest;
logic                  b_is_imm;
logic [31:0]           imm;
logic [32:0]           res_a;
logic [32:0]           res_b;

// returns {ready, value}
function automatic logic [32:0] resolve(
	input logic        busy,
	input logic [31:0] rf_val,
	input logic        rob_done,
	input logic [31:0] rob_val,
	input logic        cdb_hit,
	input logic [31:0] cdb_val
);
	if (!busy)
		return {1'b1, rf_val};
	if (rob_done)
		return {1'b1, rob_val};
	if (cdb_hit)
		return {1'b1, cdb_val};
	return {1'b0, 32'b0};
endfunction

assign ins = fetch_instr;

// unused operands read r0, which resolves to a ready zero
always_comb begin
	alu_op   = ALU_ADD;
	dest     = '0;
	raddr_a  = '0;
	raddr_b  = '0;
	b_is_imm = 1'b1;
	imm      = '0;
	case (ins.r.opcode)
		OP_RTYPE: begin
			dest     = ins.r.rd;
			raddr_a  = ins.r.rs;
			raddr_b  = ins.r.rt;
			b_is_imm = 1'b0;
			case (ins.r.funct)
				FN_ADD: alu_op = ALU_ADD;
				FN_SUB: alu_op = ALU_SUB;
				FN_AND: alu_op = ALU_AND;
				FN_OR:  alu_op = ALU_OR;
				FN_XOR: alu_op = ALU_XOR;
				FN_SLT: alu_op = ALU_SLT;
				FN_SLL: begin
					// shifts rt by shamt
					alu_op   = ALU_SLL;
					raddr_a  = ins.r.rt;
					raddr_b  = '0;
					b_is_imm = 1'b1;
					imm      = {27'b0, ins.r.shamt};
				end
				default: begin
					// unknown funct retires as 0 into r0
					dest     = '0;
					raddr_a  = '0;
					raddr_b  = '0;
					b_is_imm = 1'b1;
				end
			endcase
		end
		OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
			dest    = ins.i.rt;
			raddr_a = (ins.i.opcode == OP_LUI) ? '0 : ins.i.rs;
			imm     = {16'b0, ins.i.imm};
			case (ins.i.opcode)
				OP_ADDI: begin
					alu_op = ALU_ADD;
					imm    = {{16{ins.i.imm[15]}}, ins.i.imm};
				end
				OP_SLTI: begin
					alu_op = ALU_SLT;
					imm    = {{16{ins.i.imm[15]}}, ins.i.imm};
				end
				OP_ANDI: alu_op = ALU_AND;
				OP_ORI:  alu_op = ALU_OR;
				OP_XORI: alu_op = ALU_XOR;
				default: alu_op = ALU_LUI;
			endcase
		end
		default: ;
	endcase
end

assign res_a = resolve(busy_a, rdata_a, rob_done_a, rob_value_a,
	cdb_valid && cdb_tag == tag_a, cdb_value);
assign res_b = b_is_imm ? {1'b1, imm} : resolve(busy_b, rdata_b, rob_done_b, rob_value_b,
	cdb_valid && cdb_tag == tag_b, cdb_value);

assign rob_raddr_a = tag_a;
assign rob_raddr_b = tag_b;

assign fetch_ack = fetch_valid && !rob_full && !rs_full;

assign rob_push        = fetch_ack;
assign rob_push_waddr  = dest;
assign status_set      = fetch_ack;
assign status_set_addr = dest;
assign status_set_tag  = rob_tail;

assign rs_push   = fetch_ack;
assign rs_alu_op = alu_op;
assign rs_rdy_a  = res_a[32];
assign rs_val_a  = res_a[31:0];
assign rs_tag_a  = tag_a;
assign rs_rdy_b  = res_b[32];
assign rs_val_b  = res_b[31:0];
assign rs_tag_b  = tag_b;
assign rs_tag    = rob_tail;

endmodule

// File: logic/instr_exec.sv
`timescale 1ns/100ps

module instr_exec import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rs_push,
	input  logic [3:0]           rs_alu_op,
	input  logic [31:0]          rs_val_a,
	input  logic                 rs_rdy_a,
	input  logic [ROB_IDX_W-1:0] rs_tag_a,
	input  logic [31:0]          rs_val_b,
	input  logic                 rs_rdy_b,
	input  logic [ROB_IDX_W-1:0] rs_tag_b,
	input  logic [ROB_IDX_W-1:0] rs_tag,
	output logic                 rs_full,
	output logic                 cdb_valid,
	output logic [ROB_IDX_W-1:0] cdb_tag,
	output logic [31:0]          cdb_value
);

logic [RS_DEPTH-1:0]  ent_valid;
logic [RS_DEPTH-1:0]  ent_rdy_a;
logic [RS_DEPTH-1:0]  ent_rdy_b;
logic [3:0]           ent_op    [RS_DEPTH];
logic [31:0]          ent_val_a [RS_DEPTH];
logic [31:0]          ent_val_b [RS_DEPTH];
logic [ROB_IDX_W-1:0] ent_tag_a [RS_DEPTH];
logic [ROB_IDX_W-1:0] ent_tag_b [RS_DEPTH];
logic [ROB_IDX_W-1:0] ent_tag   [RS_DEPTH];

logic [ROB_IDX_W-1:0] next_tag;
logic [RS_IDX_W-1:0]  alloc_idx;
logic [RS_IDX_W-1:0]  sel_idx;
logic                 sel_found;
logic [ROB_IDX_W-1:0] sel_age;
logic [ROB_IDX_W-1:0] age;
logic                 wake_a;
logic                 wake_b;
logic [31:0]          op_a;
logic [31:0]          op_b;
logic [31:0]          alu_result;

assign rs_full = &ent_valid;
assign wake_a  = cdb_valid && (cdb_tag == rs_tag_a);
assign wake_b  = cdb_valid && (cdb_tag == rs_tag_b);

// lowest free slot
always_comb begin
	alloc_idx = '0;
	for (int i = RS_DEPTH - 1; i >= 0; i--) begin
		if (!ent_valid[i])
			alloc_idx = RS_IDX_W'(i);
	end
end

// age relative to the rob tail, smallest is oldest
always_comb begin
	sel_found = 1'b0;
	sel_idx   = '0;
	sel_age   = '0;
	age       = '0;
	for (int i = 0; i < RS_DEPTH; i++) begin
		age = ent_tag[i] - next_tag;
		if (ent_valid[i] && ent_rdy_a[i] && ent_rdy_b[i] && (!sel_found || age < sel_age)) begin
			sel_found = 1'b1;
			sel_idx   = RS_IDX_W'(i);
			sel_age   = age;
		end
	end
end

assign op_a = ent_val_a[sel_idx];
assign op_b = ent_val_b[sel_idx];

always_comb begin
	case (ent_op[sel_idx])
		ALU_ADD: alu_result = op_a + op_b;
		ALU_SUB: alu_result = op_a - op_b;
		ALU_AND: alu_result = op_a & op_b;
		ALU_OR:  alu_result = op_a | op_b;
		ALU_XOR: alu_result = op_a ^ op_b;
		ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
		ALU_SLL: alu_result = op_a << op_b[4:0];
		ALU_LUI: alu_result = {op_b[15:0], 16'b0};
		default: alu_result = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		ent_valid <= '0;
		ent_rdy_a <= '0;
		ent_rdy_b <= '0;
		next_tag  <= '0;
		cdb_valid <= 1'b0;
	end else begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (cdb_valid && ent_tag_a[i] == cdb_tag)
				ent_rdy_a[i] <= 1'b1;
			if (cdb_valid && ent_tag_b[i] == cdb_tag)
				ent_rdy_b[i] <= 1'b1;
		end
		if (sel_found)
			ent_valid[sel_idx] <= 1'b0;
		if (rs_push) begin
			ent_valid[alloc_idx] <= 1'b1;
			ent_rdy_a[alloc_idx] <= rs_rdy_a || wake_a;
			ent_rdy_b[alloc_idx] <= rs_rdy_b || wake_b;
			next_tag             <= rs_tag + 1'b1;
		end
		cdb_valid <= sel_found;
	end
end

always_ff @(posedge clk) begin
	for (int i = 0; i < RS_DEPTH; i++) begin
		if (cdb_valid && !ent_rdy_a[i] && ent_tag_a[i] == cdb_tag)
			ent_val_a[i] <= cdb_value;
		if (cdb_valid && !ent_rdy_b[i] && ent_tag_b[i] == cdb_tag)
			ent_val_b[i] <= cdb_value;
	end
	if (rs_push) begin
		ent_op[alloc_idx]    <= rs_alu_op;
		ent_val_a[alloc_idx] <= rs_rdy_a ? rs_val_a : cdb_value;
		ent_val_b[alloc_idx] <= rs_rdy_b ? rs_val_b : cdb_value;
		ent_tag_a[alloc_idx] <= rs_tag_a;
		ent_tag_b[alloc_idx] <= rs_tag_b;
		ent_tag[alloc_idx]   <= rs_tag;
	end
	cdb_tag   <= ent_tag[sel_idx];
	cdb_value <= alu_result;
end

endmodule

// File: logic/instr_commit.sv
`timescale 1ns/100ps

module instr_commit import cpu_pkg::*; (
	input  logic                  rob_head_valid,
	input  logic                  rob_head_done,
	input  logic [REG_ADDR_W-1:0] rob_head_waddr,
	input  logic [31:0]           rob_head_value,
	input  logic [ROB_IDX_W-1:0]  rob_head_tag,
	output logic                  rob_pop,
	output logic                  reg_we,
	output logic [REG_ADDR_W-1:0] reg_waddr,
	output logic [31:0]           reg_wdata,
	output logic                  status_clr,
	output logic [REG_ADDR_W-1:0] status_clr_addr,
	output logic [ROB_IDX_W-1:0]  status_clr_tag,
	output logic                  commit_valid,
	output logic [REG_ADDR_W-1:0] commit_waddr,
	output logic [31:0]           commit_wdata
);

logic retire;

assign retire = rob_head_valid && rob_head_done;

assign rob_pop = retire;

// r0 commits are reported but not written
assign reg_we    = retire && (rob_head_waddr != '0);
assign reg_waddr = rob_head_waddr;
assign reg_wdata = rob_head_value;

assign status_clr      = retire;
assign status_clr_addr = rob_head_waddr;
assign status_clr_tag  = rob_head_tag;

assign commit_valid = retire;
assign commit_waddr = rob_head_waddr;
assign commit_wdata = rob_head_value;

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  imem_read,
	output logic [31:0]           imem_addr,
	input  logic [31:0]           imem_rdata,
	output logic                  commit_valid,
	output logic [REG_ADDR_W-1:0] commit_waddr,
	output logic [31:0]           commit_wdata
);

// fetch to issue
logic        fetch_valid, fetch_ack;
logic [31:0] fetch_instr;

// register file and status
logic [REG_ADDR_W-1:0] raddr_a, raddr_b, reg_waddr;
logic [31:0]           rdata_a, rdata_b, reg_wdata;
logic                  reg_we, busy_a, busy_b;
logic [ROB_IDX_W-1:0]  tag_a, tag_b;
logic                  status_set, status_clr;
logic [REG_ADDR_W-1:0] status_set_addr, status_clr_addr;
logic [ROB_IDX_W-1:0]  status_set_tag, status_clr_tag;

// rob
logic                  rob_push, rob_pop, rob_full;
logic [REG_ADDR_W-1:0] rob_push_waddr, rob_head_waddr;
logic [ROB_IDX_W-1:0]  rob_tail, rob_raddr_a, rob_raddr_b, rob_head_tag;
logic                  rob_done_a, rob_done_b, rob_head_valid, rob_head_done;
logic [31:0]           rob_value_a, rob_value_b, rob_head_value;

// reservation station and cdb
logic                 rs_push, rs_full, rs_rdy_a, rs_rdy_b, cdb_valid;
logic [3:0]           rs_alu_op;
logic [31:0]          rs_val_a, rs_val_b, cdb_value;
logic [ROB_IDX_W-1:0] rs_tag_a, rs_tag_b, rs_tag, cdb_tag;

regfile regfile_inst (
	.clk,
	.rst_n,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata )
);

reg_status reg_status_inst (
	.clk,
	.rst_n,
	.raddr_a,
	.raddr_b,
	.busy_a,
	.busy_b,
	.tag_a,
	.tag_b,
	.status_set,
	.status_set_addr,
	.status_set_tag,
	.status_clr,
	.status_clr_addr,
	.status_clr_tag
);

rob rob_inst (
	.clk,
	.rst_n,
	.rob_push,
	.rob_push_waddr,
	.rob_tail,
	.rob_full,
	.cdb_valid,
	.cdb_tag,
	.cdb_value,
	.rob_raddr_a,
	.rob_raddr_b,
	.rob_done_a,
	.rob_value_a,
	.rob_done_b,
	.rob_value_b,
	.rob_head_valid,
	.rob_head_done,
	.rob_head_waddr,
	.rob_head_value,
	.rob_head_tag,
	.rob_pop
);

instr_fetch instr_fetch_inst (
	.clk,
	.rst_n,
	.imem_read,
	.imem_addr,
	.imem_rdata,
	.fetch_valid,
	.fetch_instr,
	.fetch_ack
);

instr_issue instr_issue_inst (
	.fetch_valid,
	.fetch_instr,
	.fetch_ack,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.busy_a,
	.tag_a,
	.busy_b,
	.tag_b,
	.rob_raddr_a,
	.rob_raddr_b,
	.rob_done_a,
	.rob_value_a,
	.rob_done_b,
	.rob_value_b,
	.cdb_valid,
	.cdb_tag,
	.cdb_value,
	.rob_full,
	.rob_tail,
	.rob_push,
	.rob_push_waddr,
	.status_set,
	.status_set_addr,
	.status_set_tag,
	.rs_full,
	.rs_push,
	.rs_alu_op,
	.rs_val_a,
	.rs_rdy_a,
	.rs_tag_a,
	.rs_val_b,
	.rs_rdy_b,
	.rs_tag_b,
	.rs_tag
);

instr_exec instr_exec_inst (
	.clk,
	.rst_n,
	.rs_push,
	.rs_alu_op,
	.rs_val_a,
	.rs_rdy_a,
	.rs_tag_a,
	.rs_val_b,
	.rs_rdy_b,
	.rs_tag_b,
	.rs_tag,
	.rs_full,
	.cdb_valid,
	.cdb_tag,
	.cdb_value
);

instr_commit instr_commit_inst (
	.rob_head_valid,
	.rob_head_done,
	.rob_head_waddr,
	.rob_head_value,
	.rob_head_tag,
	.rob_pop,
	.reg_we,
	.reg_waddr,
	.reg_wdata,
	.status_clr,
	.status_clr_addr,
	.status_clr_tag,
	.commit_valid,
	.commit_waddr,
	.commit_wdata
);

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

initial begin
	clk = 1'b0;
	forever #(PERIOD_NS / 2) clk = ~clk;
end

// reset released on a rising edge
initial begin
	rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	rst_n <= 1'b1;
end

endmodule

// File: tests/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb import cpu_pkg::*; ();

localparam int PROG_LEN       = 200;
localparam int RESET_CYCLES   = 10;
localparam int TIMEOUT_CYCLES = PROG_LEN * 20 + RESET_CYCLES;

logic                  clk;
logic                  rst_n;
logic                  imem_read;
logic [31:0]           imem_addr;
logic [31:0]           imem_rdata;
logic                  commit_valid;
logic [REG_ADDR_W-1:0] commit_waddr;
logic [31:0]           commit_wdata;

integer      seed;
instr_t      prog      [PROG_LEN];
logic [4:0]  exp_waddr [PROG_LEN];
logic [31:0] exp_wdata [PROG_LEN];
int          commits_seen;
int          checks;
int          errors;
logic [31:0] next_fetch_addr;

clock_gen #(
	.PERIOD_NS    ( 8            ),
	.RESET_CYCLES ( RESET_CYCLES )
) clock_gen_inst (
	.clk,
	.rst_n
);

cpu_core i_cpu_core (
	.clk,
	.rst_n,
	.imem_read,
	.imem_addr,
	.imem_rdata,
	.commit_valid,
	.commit_waddr,
	.commit_wdata
);

// mostly r0..r7 so that dependences are frequent
function automatic logic [4:0] pick_reg();
	logic [31:0] r;
	r = $random(seed);
	if (r[3:2] != 2'b00)
		return {2'b00, r[6:4]};
	return r[12:8];
endfunction

function automatic logic [31:0] imem_word(input logic [31:0] addr);
	if (addr[31:2] < PROG_LEN)
		return prog[addr[31:2]];
	// beyond the program: sll r0,r0,0
	return '0;
endfunction

task automatic build_program();
	logic [31:0] r;
	instr_t      ins;
	for (int n = 0; n < PROG_LEN; n++) begin
		r   = $random(seed);
		ins = '0;
		if (r[0]) begin
			ins.r.opcode = OP_RTYPE;
			ins.r.rs     = pick_reg();
			ins.r.rt     = pick_reg();
			ins.r.rd     = pick_reg();
			ins.r.shamt  = r[12:8];
			case (r[3:1])
				3'd0:    ins.r.funct = FN_ADD;
				3'd1:    ins.r.funct = FN_SUB;
				3'd2:    ins.r.funct = FN_AND;
				3'd3:    ins.r.funct = FN_OR;
				3'd4:    ins.r.funct = FN_XOR;
				3'd5:    ins.r.funct = FN_SLT;
				3'd6:    ins.r.funct = FN_SLL;
				default: ins.r.funct = FN_ADD;
			endcase
		end else begin
			ins.i.rs = pick_reg();
			ins.i.rt = pick_reg();
			// small signed values now and then, near zero for slti
			ins.i.imm = r[4] ? {{12{r[31]}}, r[19:16]} : r[31:16];
			case (r[7:5])
				3'd0:    ins.i.opcode = OP_ADDI;
				3'd1:    ins.i.opcode = OP_SLTI;
				3'd2:    ins.i.opcode = OP_ANDI;
				3'd3:    ins.i.opcode = OP_ORI;
				3'd4:    ins.i.opcode = OP_XORI;
				3'd5:    ins.i.opcode = OP_LUI;
				3'd6:    ins.i.opcode = OP_ADDI;
				default: ins.i.opcode = OP_SLTI;
			endcase
		end
		prog[n] = ins;
	end
endtask

// in-order reference execution of the program
task automatic run_model();
	logic [31:0] regs [REG_NUM];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] v;
	logic [4:0]  d;
	instr_t      ins;
	for (int i = 0; i < REG_NUM; i++)
		regs[i] = '0;
	for (int n = 0; n < PROG_LEN; n++) begin
		ins  = prog[n];
		sext = {{16{ins.i.imm[15]}}, ins.i.imm};
		zext = {16'b0, ins.i.imm};
		d    = '0;
		v    = '0;
		if (ins.r.opcode == OP_RTYPE) begin
			a = regs[ins.r.rs];
			b = regs[ins.r.rt];
			d = ins.r.rd;
			case (ins.r.funct)
				FN_ADD:  v = a + b;
				FN_SUB:  v = a - b;
				FN_AND:  v = a & b;
				FN_OR:   v = a | b;
				FN_XOR:  v = a ^ b;
				FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLL:  v = b << ins.r.shamt;
				default: d = '0;
			endcase
		end else begin
			a = regs[ins.i.rs];
			d = ins.i.rt;
			case (ins.i.opcode)
				OP_ADDI: v = a + sext;
				OP_SLTI: v = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
				OP_ANDI: v = a & zext;
				OP_ORI:  v = a | zext;
				OP_XORI: v = a ^ zext;
				OP_LUI:  v = {ins.i.imm, 16'b0};
				default: d = '0;
			endcase
		end
		exp_waddr[n] = d;
		exp_wdata[n] = v;
		if (d != '0)
			regs[d] = v;
	end
endtask

task automatic report_counts();
	$display("commits %0d, checks %0d, errors %0d", commits_seen, checks, errors);
endtask

task automatic check_reset_state();
	checks++;
	assert (imem_read == 1'b0) else begin
		errors++;
		$display("FAILED imem_read after reset: got %h, expected %h", imem_read, 1'b0);
	end
	checks++;
	assert (commit_valid == 1'b0) else begin
		errors++;
		$display("FAILED commit_valid after reset: got %h, expected %h", commit_valid, 1'b0);
	end
	checks++;
	assert (imem_addr == 32'h0) else begin
		errors++;
		$display("FAILED imem_addr after reset: got %h, expected %h", imem_addr, 32'h0);
	end
endtask

// instruction memory, one cycle read latency
always @(posedge clk) begin
	if (imem_read)
		imem_rdata <= imem_word(imem_addr);
end

// requests must walk the program word by word from 0
always @(negedge clk) begin
	if (rst_n && imem_read) begin
		checks++;
		assert (imem_addr == next_fetch_addr) else begin
			errors++;
			$display("FAILED imem_addr: got %h, expected %h", imem_addr, next_fetch_addr);
		end
		next_fetch_addr = next_fetch_addr + 32'd4;
	end
end

always @(negedge clk) begin : commit_check
	logic [4:0]  want_waddr;
	logic [31:0] want_wdata;
	if (rst_n && commit_valid) begin
		want_waddr = '0;
		want_wdata = '0;
		if (commits_seen < PROG_LEN) begin
			want_waddr = exp_waddr[commits_seen];
			want_wdata = exp_wdata[commits_seen];
		end
		checks++;
		assert (commit_waddr == want_waddr) else begin
			errors++;
			$display("FAILED commit_waddr at commit %0d: got %h, expected %h",
				commits_seen, commit_waddr, want_waddr);
		end
		checks++;
		assert (commit_wdata == want_wdata) else begin
			errors++;
			$display("FAILED commit_wdata at commit %0d: got %h, expected %h",
				commits_seen, commit_wdata, want_wdata);
		end
		commits_seen++;
	end
end

initial begin
	seed            = 32'hc327;
	commits_seen    = 0;
	checks          = 0;
	errors          = 0;
	next_fetch_addr = '0;
	imem_rdata      = '0;
	build_program();
	run_model();
	@(posedge rst_n);
	@(negedge clk);
	check_reset_state();
	wait (commits_seen >= PROG_LEN);
	repeat (4) @(negedge clk);
	report_counts();
	if (errors == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

// watchdog
initial begin
	repeat (TIMEOUT_CYCLES) @(posedge clk);
	errors++;
	$display("timeout: only %0d of %0d instructions committed before the limit",
		commits_seen, PROG_LEN);
	report_counts();
	$display("Done: errors found");
	$finish;
end

endmodule

// File: sim.f
logic/cpu_pkg.sv
logic/regfile.sv
logic/reg_status.sv
logic/rob.sv
logic/instr_fetch.sv
logic/instr_issue.sv
logic/instr_exec.sv
logic/instr_commit.sv
logic/cpu_core.sv
tests/clock_gen.sv
tests/cpu_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_core_tb
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
